// File: tests/fir_input.txt
// per run: tap count and data length, then the coefficients,
// then the input samples and the expected outputs, all in hex
// run 1 with 11 taps and 20 samples
b 14
1 2 3 4 5 6 7 8 9 a b
// samples
1 2 3 4 5 6 7 8 9 a
b c d e f 10 11 12 13 14
// expected outputs
1 4 a 14 23 38 54 78 a5 dc
11e 160 1a2 1e4 226 268 2aa 2ec 32e 370
// run 2 with 5 taps and 12 samples, one negative coefficient
5 c
2 ffffffff 0 3 1
// samples
5 1 7 2 0 9 4 6 3 8 1 2
// expected outputs
a fffffffd d c 6 28 c a 1b 22 10 12
// end of the list
0

// File: project.f
+incdir+verilog
verilog/fir_pkg.sv
verilog/fir_axil_regs.sv
verilog/fir_tap_ram.sv
verilog/fir_engine.sv
verilog/fir_top.sv
tests/fir_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/100ps
TOP       := fir_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) verilog/fir_config.svh

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

// File: tests/fir_tb.sv
`include "fir_config.svh"

module fir_tb import fir_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_WORDS = 256;
    localparam int MAX_RUNS  = 4;

    logic                   axis_clk;
    logic                   axis_rst_n;
    logic                   awvalid;
    logic                   wvalid;
    logic [`FIR_ADDR_W-1:0] awaddr;
    sample_t                wdata;
    logic                   awready;
    logic                   wready;
    logic                   arvalid;
    logic                   rready;
    logic [`FIR_ADDR_W-1:0] araddr;
    logic                   arready;
    logic                   rvalid;
    sample_t                rdata;
    logic                   ss_tvalid;
    logic                   ss_tready;
    sample_t                ss_tdata;
    logic                   ss_tlast;
    logic                   sm_tvalid;
    logic                   sm_tready;
    sample_t                sm_tdata;
    logic                   sm_tlast;

    sample_t     vec [MAX_WORDS];
    int          run_taps [MAX_RUNS];
    int          run_len [MAX_RUNS];
    int          run_base [MAX_RUNS];
    int          num_runs;
    int          total_samples;
    int          errors;
    int          checks;
    int          cycles;
    int          limit;
    logic [31:0] src_state;
    logic [31:0] snk_state;

    fir_top i_fir_top (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .wvalid     (wvalid),
        .awaddr     (awaddr),
        .wdata      (wdata),
        .awready    (awready),
        .wready     (wready),
        .arvalid    (arvalid),
        .rready     (rready),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tready  (ss_tready),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .sm_tvalid  (sm_tvalid),
        .sm_tready  (sm_tready),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast)
    );

    initial begin
        axis_clk = 1'b0;
        forever #4 axis_clk = ~axis_clk;
    end

    // limit is zero until the data file has been read
    always @(posedge axis_clk) begin
        cycles = cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: run stopped after %0d cycles with %0d errors", cycles, errors);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic ap_ctrl_u ctrl_word(input logic start_bit, input logic done_bit,
                                           input logic idle_bit);
        ap_ctrl_u c;
        c            = '0;
        c.f.ap_start = start_bit;
        c.f.ap_done  = done_bit;
        c.f.ap_idle  = idle_bit;
        return c;
    endfunction

    task automatic check_word(input string name, input sample_t got, input sample_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_ctrl(input string name, input ap_ctrl_u got, input ap_ctrl_u exp);
        checks++;
        if (got.f.ap_start !== exp.f.ap_start || got.f.ap_done !== exp.f.ap_done
            || got.f.ap_idle !== exp.f.ap_idle || got.f.pad !== exp.f.pad) begin
            errors++;
            $display("error: %s got %h expected %h", name, got.word, exp.word);
        end
    endtask

    task automatic count_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    // everything is driven and sampled 1 ns after the edge
    task automatic next_cycle();
        @(posedge axis_clk);
        #1;
    endtask

    task automatic axil_write(input logic [`FIR_ADDR_W-1:0] addr, input sample_t data);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        next_cycle();
        while (!(awready && wready)) begin
            next_cycle();
        end
        // taken at the coming edge
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic axil_read(input logic [`FIR_ADDR_W-1:0] addr, output sample_t data);
        araddr  = addr;
        arvalid = 1'b1;
        next_cycle();
        while (!arready) begin
            next_cycle();
        end
        next_cycle();
        arvalid = 1'b0;
        rready  = 1'b1;
        while (!rvalid) begin
            next_cycle();
        end
        data = rdata;
        next_cycle();
        rready = 1'b0;
    endtask

    task automatic send_samples(input int base, input int len);
        int   sent;
        logic xfer;
        sent = 0;
        while (sent < len) begin
            // random gaps only between samples, valid holds once raised
            if (!ss_tvalid) begin
                src_state = lcg_next(src_state);
                if (src_state[17:16] != 2'b00) begin
                    ss_tvalid = 1'b1;
                    ss_tdata  = vec[base + sent];
                    ss_tlast  = (sent == len - 1);
                end
            end
            xfer = ss_tvalid && ss_tready;
            next_cycle();
            if (xfer) begin
                sent++;
                ss_tvalid = 1'b0;
                ss_tlast  = 1'b0;
            end
        end
    endtask

    task automatic collect_outputs(input int base, input int len);
        int      got;
        logic    held;
        sample_t held_data;
        got       = 0;
        held      = 1'b0;
        held_data = '0;
        while (got < len) begin
            snk_state = lcg_next(snk_state);
            sm_tready = (snk_state[21:20] != 2'b00);
            if (held && !sm_tvalid) begin
                count_failure("sm_tvalid dropped before its output was taken");
                held = 1'b0;
            end else if (held) begin
                check_word("sm_tdata while held", sm_tdata, held_data);
            end
            if (sm_tvalid && sm_tready) begin
                check_word($sformatf("sm_tdata[%0d]", got), sm_tdata, vec[base + got]);
                if (sm_tlast && got != len - 1) begin
                    count_failure("sm_tlast set before the final output");
                end
                if (!sm_tlast && got == len - 1) begin
                    count_failure("sm_tlast missing on the final output");
                end
                got++;
                held = 1'b0;
            end else if (sm_tvalid) begin
                held      = 1'b1;
                held_data = sm_tdata;
            end
            next_cycle();
        end
        sm_tready = 1'b0;
    endtask

    task automatic watch_for_extra();
        logic seen;
        seen      = 1'b0;
        sm_tready = 1'b1;
        repeat (`FIR_TAP_MAX + 5) begin
            if (sm_tvalid && !seen) begin
                count_failure("extra output on the output stream after the final one");
                seen = 1'b1;
            end
            next_cycle();
        end
        sm_tready = 1'b0;
    endtask

    initial begin
        int       p;
        int       r;
        int       taps;
        int       len;
        int       base;
        sample_t  rd;
        ap_ctrl_u ctrl;
        axis_rst_n    = 1'b0;
        awvalid       = 1'b0;
        wvalid        = 1'b0;
        awaddr        = '0;
        wdata         = '0;
        arvalid       = 1'b0;
        rready        = 1'b0;
        araddr        = '0;
        ss_tvalid     = 1'b0;
        ss_tdata      = '0;
        ss_tlast      = 1'b0;
        sm_tready     = 1'b0;
        errors        = 0;
        checks        = 0;
        cycles        = 0;
        limit         = 0;
        num_runs      = 0;
        total_samples = 0;
        src_state     = 32'd8339;
        snk_state     = 32'd8339;

        // runs are packed back to back, a zero tap count ends them
        $readmemh("tests/fir_input.txt", vec);
        p = 0;
        while (num_runs < MAX_RUNS && p < MAX_WORDS - 2 && vec[p] != '0) begin
            run_taps[num_runs] = int'(vec[p]);
            run_len[num_runs]  = int'(vec[p + 1]);
            run_base[num_runs] = p + 2;
            total_samples      = total_samples + run_len[num_runs];
            p = p + 2 + run_taps[num_runs] + 2 * run_len[num_runs];
            num_runs++;
        end
        limit = total_samples * (`FIR_TAP_MAX + 10) * 2 + 500;
        if (num_runs == 0) begin
            count_failure("no runs found in tests/fir_input.txt");
        end

        repeat (5) @(posedge axis_clk);
        #1;
        axis_rst_n = 1'b1;
        next_cycle();

        axil_read(`FIR_ADDR_CTRL, rd);
        ctrl.word = rd;
        check_ctrl("ap_ctrl after reset", ctrl, ctrl_word(1'b0, 1'b0, 1'b1));
        axil_read(12'h040, rd);
        check_word("rdata unmapped", rd, '1);
        axil_read(`FIR_ADDR_COEF, rd);
        check_word("rdata coefficient", rd, '1);

        for (r = 0; r < num_runs; r++) begin
            taps = run_taps[r];
            len  = run_len[r];
            base = run_base[r];
            for (int i = 0; i < taps; i++) begin
                axil_write(`FIR_ADDR_COEF + 12'(4 * i), vec[base + i]);
            end
            axil_write(`FIR_ADDR_LEN, sample_t'(len));
            axil_write(`FIR_ADDR_TAPS, sample_t'(taps));
            axil_read(`FIR_ADDR_LEN, rd);
            check_word("data_length", rd, sample_t'(len));
            axil_read(`FIR_ADDR_TAPS, rd);
            check_word("tap_num", rd, sample_t'(taps));
            axil_write(`FIR_ADDR_CTRL, 32'h1);

            // busy now, so this write must not land
            axil_write(`FIR_ADDR_LEN, sample_t'(len + 7));
            axil_read(`FIR_ADDR_LEN, rd);
            check_word("data_length while busy", rd, sample_t'(len));

            fork
                send_samples(base + taps, len);
                collect_outputs(base + taps + len, len);
            join
            watch_for_extra();

            axil_read(`FIR_ADDR_CTRL, rd);
            ctrl.word = rd;
            check_ctrl("ap_ctrl after run", ctrl, ctrl_word(1'b0, 1'b1, 1'b0));
            axil_read(`FIR_ADDR_CTRL, rd);
            ctrl.word = rd;
            check_ctrl("ap_ctrl after done read", ctrl, ctrl_word(1'b0, 1'b0, 1'b1));
        end

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog/fir_top.sv
`include "fir_config.svh"

module fir_top import fir_pkg::*; (
    input  logic                   axis_clk,
    input  logic                   axis_rst_n,
    input  logic                   awvalid,
    input  logic                   wvalid,
    input  logic [`FIR_ADDR_W-1:0] awaddr,
    input  sample_t                wdata,
    output logic                   awready,
    output logic                   wready,
    input  logic                   arvalid,
    input  logic                   rready,
    input  logic [`FIR_ADDR_W-1:0] araddr,
    output logic                   arready,
    output logic                   rvalid,
    output sample_t                rdata,
    input  logic                   ss_tvalid,
    output logic                   ss_tready,
    input  sample_t                ss_tdata,
    input  logic                   ss_tlast,
    output logic                   sm_tvalid,
    input  logic                   sm_tready,
    output sample_t                sm_tdata,
    output logic                   sm_tlast
);

    fir_cfg_t cfg;
    coef_wr_t coef_wr;
    tap_idx_t coef_idx;
    sample_t  coef;
    logic     start;
    logic     run_done;

    fir_axil_regs i_fir_axil_regs (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .wvalid     (wvalid),
        .awaddr     (awaddr),
        .wdata      (wdata),
        .awready    (awready),
        .wready     (wready),
        .arvalid    (arvalid),
        .rready     (rready),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .run_done   (run_done),
        .cfg        (cfg),
        .start      (start),
        .coef_wr    (coef_wr)
    );

    fir_tap_ram i_fir_tap_ram (
        .axis_clk (axis_clk),
        .coef_wr  (coef_wr),
        .coef_idx (coef_idx),
        .coef     (coef)
    );

    fir_engine i_fir_engine (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .cfg        (cfg),
        .start      (start),
        .coef_idx   (coef_idx),
        .coef       (coef),
        .run_done   (run_done),
        .ss_tvalid  (ss_tvalid),
        .ss_tready  (ss_tready),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .sm_tvalid  (sm_tvalid),
        .sm_tready  (sm_tready),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast)
    );

endmodule

// File: verilog/fir_engine.sv
`include "fir_config.svh"

module fir_engine import fir_pkg::*; (
    input  logic     axis_clk,
    input  logic     axis_rst_n,
    input  fir_cfg_t cfg,
    input  logic     start,
    output tap_idx_t coef_idx,
    input  sample_t  coef,
    output logic     run_done,
    input  logic     ss_tvalid,
    output logic     ss_tready,
    input  sample_t  ss_tdata,
    input  logic     ss_tlast,
    output logic     sm_tvalid,
    input  logic     sm_tready,
    output sample_t  sm_tdata,
    output logic     sm_tlast
);

    logic                   run;
    logic [`FIR_DATA_W-1:0] x_cnt;
    logic [`FIR_DATA_W-1:0] y_cnt;
    logic                   in_full;
    sample_t                in_data;
    sample_t                hist [`FIR_TAP_MAX];
    tap_idx_t               wptr;
    tap_idx_t               wnext;
    tap_idx_t               tap_cnt;
    tap_idx_t               t1;
    tap_idx_t               rd_idx;
    logic                   calc;
    logic                   issue;
    logic                   issue_now;
    logic                   load;
    logic                   tap_last;
    logic                   v1, v2, v3;
    logic                   l1, l2, l3;
    logic                   f2, f3;
    sample_t                x_reg;
    sample_t                h_reg;
    sample_t                mul_reg;
    sample_t                acc;
    sample_t                acc_sum;
    logic                   ss_hs;
    logic                   sm_hs;
    logic                   stall;
    logic                   place;

    // ss_tlast is not used, the sample count comes from cfg
    assign ss_hs     = ss_tvalid && ss_tready;
    assign sm_hs     = sm_tvalid && sm_tready;
    assign ss_tready = run && !in_full && (x_cnt != cfg.data_length);
    assign run_done  = sm_hs && sm_tlast;

    // one x in the MAC at a time
    assign load      = run && in_full && !calc;
    assign issue_now = load || issue;
    assign tap_last  = (tap_cnt == cfg.tap_num - 1'b1);
    assign coef_idx  = tap_cnt;

    assign wnext  = (wptr == tap_idx_t'(`FIR_TAP_MAX - 1)) ? '0 : wptr + 1'b1;
    // x[n-i] walks back from the newest slot
    assign rd_idx = (wptr >= t1) ? wptr - t1 : tap_idx_t'(`FIR_TAP_MAX) - (t1 - wptr);

    assign acc_sum = f3 ? mul_reg : acc + mul_reg;
    // final sum waits here while the output buffer is held
    assign stall   = v3 && l3 && sm_tvalid && !sm_tready;
    assign place   = v3 && l3 && !stall;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            run     <= 1'b0;
            in_full <= 1'b0;
            x_cnt   <= '0;
            y_cnt   <= '0;
        end else if (start) begin
            run     <= 1'b1;
            in_full <= 1'b0;
            x_cnt   <= '0;
            y_cnt   <= '0;
        end else begin
            if (run_done) begin
                run <= 1'b0;
            end
            if (ss_hs) begin
                in_full <= 1'b1;
                x_cnt   <= x_cnt + 1'b1;
            end else if (load) begin
                in_full <= 1'b0;
            end
            if (place) begin
                y_cnt <= y_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (ss_hs) begin
            in_data <= ss_tdata;
        end
    end

    // history starts from zeros each run
    always_ff @(posedge axis_clk) begin
        if (start) begin
            for (int i = 0; i < `FIR_TAP_MAX; i++) begin
                hist[i] <= '0;
            end
        end else if (load) begin
            hist[wnext] <= in_data;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wptr    <= '0;
            calc    <= 1'b0;
            issue   <= 1'b0;
            tap_cnt <= '0;
        end else begin
            if (start) begin
                wptr <= '0;
            end else if (load) begin
                wptr <= wnext;
            end
            if (load) begin
                calc <= 1'b1;
            end else if (place) begin
                calc <= 1'b0;
            end
            if (issue_now) begin
                issue   <= !tap_last;
                tap_cnt <= tap_last ? '0 : tap_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
        end else begin
            v1 <= issue_now;
            v2 <= v1;
            v3 <= v2 || stall;
        end
    end

    // x/h, product, then accumulate
    always_ff @(posedge axis_clk) begin
        t1    <= tap_cnt;
        l1    <= tap_last;
        x_reg <= hist[rd_idx];
        h_reg <= coef;
        f2    <= (t1 == '0);
        l2    <= l1;
        if (!stall) begin
            mul_reg <= x_reg * h_reg;
            f3      <= f2;
            l3      <= l2;
        end
        if (v3 && !l3) begin
            acc <= acc_sum;
        end
        if (place) begin
            sm_tdata <= acc_sum;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end else if (place) begin
            sm_tvalid <= 1'b1;
            sm_tlast  <= (y_cnt + 1'b1 == cfg.data_length);
        end else if (sm_hs) begin
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end
    end

endmodule

// File: verilog/fir_tap_ram.sv
`include "fir_config.svh"

module fir_tap_ram import fir_pkg::*; (
    input  logic     axis_clk,
    input  coef_wr_t coef_wr,
    input  tap_idx_t coef_idx,
    output sample_t  coef
);

    sample_t mem [`FIR_TAP_MAX];

    always_ff @(posedge axis_clk) begin
        if (coef_wr.en) begin
            mem[coef_wr.idx] <= coef_wr.data;
        end
        // registered read, one cycle
        coef <= mem[coef_idx];
    end

endmodule

// File: verilog/fir_axil_regs.sv
`include "fir_config.svh"

module fir_axil_regs import fir_pkg::*; (
    input  logic                   axis_clk,
    input  logic                   axis_rst_n,
    input  logic                   awvalid,
    input  logic                   wvalid,
    input  logic [`FIR_ADDR_W-1:0] awaddr,
    input  sample_t                wdata,
    output logic                   awready,
    output logic                   wready,
    input  logic                   arvalid,
    input  logic                   rready,
    input  logic [`FIR_ADDR_W-1:0] araddr,
    output logic                   arready,
    output logic                   rvalid,
    output sample_t                rdata,
    input  logic                   run_done,
    output fir_cfg_t               cfg,
    output logic                   start,
    output coef_wr_t               coef_wr
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_DONE
    } run_state_t;

    run_state_t             state;
    logic [`FIR_ADDR_W-1:0] rd_addr;
    logic [`FIR_ADDR_W-1:0] coef_off;
    logic                   wr_hs;
    logic                   rd_hs;
    logic                   cfg_wr;
    sample_t                rd_word;
    ap_ctrl_u               ctrl;

    // address and data taken together, ready pulses a cycle later
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !wready;
            wready  <= awvalid && wvalid && !wready;
        end
    end

    assign wr_hs  = awready && wready;
    // config only changes while idle
    assign cfg_wr = wr_hs && (state == ST_IDLE);
    assign start  = cfg_wr && (awaddr == `FIR_ADDR_CTRL) && wdata[`FIR_CTRL_START_BIT];

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            cfg <= '0;
        end else if (cfg_wr) begin
            if (awaddr == `FIR_ADDR_LEN) begin
                cfg.data_length <= wdata;
            end
            if (awaddr == `FIR_ADDR_TAPS) begin
                cfg.tap_num <= wdata[`FIR_TAP_IDX_W-1:0];
            end
        end
    end

    // coefficient window, one word per tap
    assign coef_off     = awaddr - `FIR_ADDR_COEF;
    assign coef_wr.en   = cfg_wr && (awaddr >= `FIR_ADDR_COEF) && (coef_off[1:0] == 2'b00)
                          && (coef_off < `FIR_ADDR_W'(4 * `FIR_TAP_MAX));
    assign coef_wr.idx  = coef_off[`FIR_TAP_IDX_W+1:2];
    assign coef_wr.data = wdata;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (start) state <= ST_BUSY;
                ST_BUSY: if (run_done) state <= ST_DONE;
                // done is cleared by the status read
                ST_DONE: if (rvalid && rready && rd_addr == `FIR_ADDR_CTRL) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // read side, address first then data
    assign rd_hs = arvalid && arready;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        ctrl            = '0;
        ctrl.f.ap_start = start;
        ctrl.f.ap_done  = (state == ST_DONE);
        ctrl.f.ap_idle  = (state == ST_IDLE);
    end

    always_comb begin
        case (araddr)
            `FIR_ADDR_CTRL: rd_word = ctrl.word;
            `FIR_ADDR_LEN:  rd_word = cfg.data_length;
            `FIR_ADDR_TAPS: rd_word = sample_t'(cfg.tap_num);
            default:        rd_word = '1;
        endcase
    end

    // word captured at the address handshake, held through rvalid
    always_ff @(posedge axis_clk) begin
        if (rd_hs) begin
            rd_addr <= araddr;
            rdata   <= rd_word;
        end
    end

endmodule

// File: verilog/fir_pkg.sv
`include "fir_config.svh"

package fir_pkg;

    typedef logic [`FIR_DATA_W-1:0]    sample_t;
    typedef logic [`FIR_TAP_IDX_W-1:0] tap_idx_t;

    // run configuration handed to the engine
    typedef struct packed {
        sample_t  data_length;
        tap_idx_t tap_num;
    } fir_cfg_t;

    // one coefficient write from the bus side
    typedef struct packed {
        logic     en;
        tap_idx_t idx;
        sample_t  data;
    } coef_wr_t;

    typedef struct packed {
        logic [`FIR_DATA_W-`FIR_CTRL_STAT_W-1:0] pad;
        logic                                    ap_idle;
        logic                                    ap_done;
        logic                                    ap_start;
    } ap_ctrl_bits_t;

    // status word, seen raw or by field
    typedef union packed {
        sample_t       word;
        ap_ctrl_bits_t f;
    } ap_ctrl_u;

endpackage

// File: verilog/fir_config.svh
`ifndef FIR_CONFIG_SVH
`define FIR_CONFIG_SVH

// bus and datapath widths
`define FIR_DATA_W    32
`define FIR_ADDR_W    12

// coefficient and history depth
`define FIR_TAP_MAX   11
`define FIR_TAP_IDX_W 4

// register map
`define FIR_ADDR_CTRL 12'h000
`define FIR_ADDR_LEN  12'h010
`define FIR_ADDR_TAPS 12'h014
`define FIR_ADDR_COEF 12'h080

// ap_ctrl holds start, done and idle from bit 0 up
`define FIR_CTRL_START_BIT 0
`define FIR_CTRL_STAT_W    3

`endif
